// ==== Makefile ====
# Verilator build and run for the merge data generator testbench
VERILATOR ?= verilator
TOP       ?= tb_merge_data_generator
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS     := $(shell grep -v '^+' $(FILELIST))
HDRS     := $(wildcard dv/*.svh)
SIM      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := *** PASSED ***

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== common/merge_pkg.sv ====
// Merge generator constants, packet, descriptor, lane mask and FSM state types
package merge_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int NUM_LANES       = 4;
    localparam int FIELD_W         = 32;
    localparam int META_W          = 16;
    localparam int COUNT_W         = 16;

    // FIFO depths must be powers of two
    localparam int LANE_FIFO_DEPTH = 16;
    localparam int OUT_FIFO_DEPTH  = 16;
    localparam int PROG_THRESH     = 8;

    // --------------------
    // Types
    // --------------------
    // Set bit means the lane takes part in the merge
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    typedef struct packed {
        logic [META_W-1:0]                 meta;
        logic [NUM_LANES-1:0][FIELD_W-1:0] field;
    } packet_t;

    // Run descriptor, only the packet count is kept
    typedef struct packed {
        logic               valid;
        logic [COUNT_W-1:0] count;
    } descriptor_t;

    typedef enum logic [2:0] {
        IDLE,
        CONFIG_REQ,
        CONFIG_RELEASE,
        BUSY,
        PAUSE,
        DONE
    } merge_state_t;

endpackage : merge_pkg

// ==== design/merge/merge_control_fsm.sv ====
// Run sequencer: config handshake, mask capture, pause, packet count and done
module merge_control_fsm (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  merge_pkg::descriptor_t descriptor,
    output logic                   config_req,
    input  logic                   config_ack,
    input  merge_pkg::lane_mask_t  config_mask,
    input  logic                   out_prog_full,
    input  logic                   merge_push,
    output logic                   merge_enable,
    output merge_pkg::lane_mask_t  merge_mask,
    output logic                   done
);
    import merge_pkg::*;

    merge_state_t       state;
    merge_state_t       next_state;
    logic [COUNT_W-1:0] remaining;
    lane_mask_t         mask_reg;
    logic               counting;
    logic               last_push;

    // Merged packets may still land while paused
    assign counting  = (state == BUSY) || (state == PAUSE);
    assign last_push = counting && merge_push && (remaining == COUNT_W'(1));

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (descriptor.valid) begin
                    next_state = CONFIG_REQ;
                end
            end
            CONFIG_REQ: begin
                if (config_ack) begin
                    next_state = CONFIG_RELEASE;
                end
            end
            // Wait for the source to drop ack before merging
            CONFIG_RELEASE: begin
                if (!config_ack) begin
                    next_state = (remaining == '0) ? DONE : BUSY;
                end
            end
            BUSY: begin
                if (last_push) begin
                    next_state = DONE;
                end else if (out_prog_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (last_push) begin
                    next_state = DONE;
                end else if (!out_prog_full) begin
                    next_state = BUSY;
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // --------------------
    // Run parameters
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            remaining <= '0;
            mask_reg  <= '0;
        end else begin
            if (state == IDLE && descriptor.valid) begin
                remaining <= descriptor.count;
            end else if (counting && merge_push) begin
                remaining <= remaining - 1'b1;
            end
            // Mask is valid on the first ack cycle
            if (state == CONFIG_REQ && config_ack) begin
                mask_reg <= config_mask;
            end
        end
    end

    assign config_req   = (state == CONFIG_REQ);
    assign merge_enable = (state == BUSY);
    assign merge_mask   = mask_reg;
    assign done         = (state == DONE);

    // Source only raises ack in answer to a request
    a_ack_after_req: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(config_ack) |-> config_req)
        else $error("config_ack rose without config_req");

    // Lane 0 supplies the metadata, so it must be merged
    a_mask_lane0: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (state == CONFIG_REQ) && config_ack |=> merge_mask[0])
        else $error("captured merge mask excludes lane 0");

endmodule : merge_control_fsm

// ==== design/merge/merge_field_combiner.sv ====
// Per-lane pop control, lane slot flags and merged packet assembly
module merge_field_combiner (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  logic                            merge_enable,
    input  merge_pkg::lane_mask_t           merge_mask,
    input  logic [merge_pkg::NUM_LANES-1:0] lane_empty,
    input  logic [merge_pkg::NUM_LANES-1:0] lane_read_valid,
    input  merge_pkg::packet_t              lane_dout [merge_pkg::NUM_LANES],
    output logic [merge_pkg::NUM_LANES-1:0] lane_pop,
    output logic                            merge_push,
    output merge_pkg::packet_t              merged_packet
);
    import merge_pkg::*;

    lane_mask_t filled;
    lane_mask_t capture;
    packet_t    assembly;
    logic       all_filled;

    // --------------------
    // Pop control
    // --------------------
    // A lane's read_valid marks the read still in flight from last cycle
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (merge_mask[i]) begin
                lane_pop[i] = merge_enable & ~filled[i] & ~lane_empty[i]
                              & ~lane_read_valid[i];
            end else begin
                // Lanes outside the mask are drained
                lane_pop[i] = merge_enable & ~lane_empty[i];
            end
        end
    end

    // Only masked lanes fill a slot
    assign capture = lane_read_valid & merge_mask;

    // Empty mask never completes a packet
    assign all_filled = (merge_mask != '0) && ((filled & merge_mask) == merge_mask);

    // --------------------
    // Slot flags
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            filled <= '0;
        end else if (all_filled) begin
            filled <= '0;
        end else begin
            filled <= filled | capture;
        end
    end

    // Assembly register, unmasked fields hold their old value
    always_ff @(posedge ap_clk) begin
        if (capture[0]) begin
            assembly.meta <= lane_dout[0].meta;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (capture[i]) begin
                assembly.field[i] <= lane_dout[i].field[i];
            end
        end
    end

    // Push in the cycle the last slot is seen full
    assign merge_push    = all_filled;
    assign merged_packet = assembly;

endmodule : merge_field_combiner

// ==== design/merge_data_generator.sv ====
// Merge data generator top: input registers, lane FIFOs, output FIFO, FSM and combiner
module merge_data_generator (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  merge_pkg::descriptor_t          descriptor,
    output logic                            config_req,
    input  logic                            config_ack,
    input  merge_pkg::lane_mask_t           config_mask,
    input  logic [merge_pkg::NUM_LANES-1:0] lane_push,
    input  merge_pkg::packet_t              lane_packet [merge_pkg::NUM_LANES],
    output logic [merge_pkg::NUM_LANES-1:0] lane_prog_full,
    input  logic                            out_rd_en,
    output logic                            out_empty,
    output logic                            out_valid,
    output merge_pkg::packet_t              out_packet,
    output logic                            done
);
    import merge_pkg::*;

    descriptor_t          descriptor_reg;
    logic [NUM_LANES-1:0] lane_push_reg;
    packet_t              lane_packet_reg [NUM_LANES];
    logic [NUM_LANES-1:0] lane_full;
    logic [NUM_LANES-1:0] lane_empty;
    logic [NUM_LANES-1:0] lane_read_valid;
    logic [NUM_LANES-1:0] lane_pop;
    packet_t              lane_dout [NUM_LANES];
    logic                 out_prog_full;
    logic                 out_pop;
    logic                 merge_enable;
    logic                 merge_push;
    lane_mask_t           merge_mask;
    packet_t              merged_packet;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            descriptor_reg.valid <= 1'b0;
            lane_push_reg        <= '0;
        end else begin
            descriptor_reg.valid <= descriptor.valid;
            lane_push_reg        <= lane_push;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_reg.count <= descriptor.count;
        lane_packet_reg      <= lane_packet;
    end

    // --------------------
    // Lane FIFOs
    // --------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        sync_fifo #(
            .WIDTH ($bits(packet_t)),
            .DEPTH (LANE_FIFO_DEPTH)
        ) u_lane_fifo (
            .ap_clk           (ap_clk),
            .areset_generator (areset_generator),
            .push             (lane_push_reg[i]),
            .din              (lane_packet_reg[i]),
            .pop              (lane_pop[i]),
            .dout             (lane_dout[i]),
            .read_valid       (lane_read_valid[i]),
            .full             (lane_full[i]),
            .empty            (lane_empty[i]),
            .prog_full        (lane_prog_full[i])
        );

        // Source push lands in the FIFO one cycle later
        a_lane_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
            lane_push[i] |=> !lane_full[i])
            else $error("lane %0d pushed into a full FIFO", i);
    end

    merge_control_fsm u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor       (descriptor_reg),
        .config_req       (config_req),
        .config_ack       (config_ack),
        .config_mask      (config_mask),
        .out_prog_full    (out_prog_full),
        .merge_push       (merge_push),
        .merge_enable     (merge_enable),
        .merge_mask       (merge_mask),
        .done             (done)
    );

    merge_field_combiner u_combiner (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .merge_enable     (merge_enable),
        .merge_mask       (merge_mask),
        .lane_empty       (lane_empty),
        .lane_read_valid  (lane_read_valid),
        .lane_dout        (lane_dout),
        .lane_pop         (lane_pop),
        .merge_push       (merge_push),
        .merged_packet    (merged_packet)
    );

    // --------------------
    // Output FIFO
    // --------------------
    assign out_pop = out_rd_en & ~out_empty;

    sync_fifo #(
        .WIDTH ($bits(packet_t)),
        .DEPTH (OUT_FIFO_DEPTH)
    ) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (merge_push),
        .din              (merged_packet),
        .pop              (out_pop),
        .dout             (out_packet),
        .read_valid       (out_valid),
        .full             (),
        .empty            (out_empty),
        .prog_full        (out_prog_full)
    );

endmodule : merge_data_generator

// ==== design/sync_fifo.sv ====
// Synchronous FIFO with occupancy count, programmable full and read valid flag
module sync_fifo #(
    parameter int WIDTH = $bits(merge_pkg::packet_t),
    parameter int DEPTH = merge_pkg::LANE_FIFO_DEPTH
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             read_valid,
    output logic             full,
    output logic             empty,
    output logic             prog_full
);
    import merge_pkg::*;

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     do_push;
    logic                     do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // --------------------
    // Status flags
    // --------------------
    assign full      = (count == DEPTH);
    assign empty     = (count == 0);
    assign prog_full = (count >= PROG_THRESH);

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            read_valid <= 1'b0;
        end else begin
            read_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read port
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            dout <= mem[rd_ptr];
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(push && full))
        else $error("sync_fifo push while full");

    a_no_underflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(pop && empty))
        else $error("sync_fifo pop while empty");

endmodule : sync_fifo

// ==== dv/merge_tests.svh ====
// Directed test tasks for the merge data generator and their run helpers
`ifndef MERGE_TESTS_SVH
`define MERGE_TESTS_SVH

// Queue packets, issue the descriptor and check config_req two cycles later
task automatic begin_run(input lane_mask_t mask, input lane_mask_t lanes, input int count);
    cur_mask = mask;
    for (int n = 0; n < count; n++) begin
        mask_q.push_back(mask);
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lanes[i]) begin
                send_q[i].push_back(random_packet());
            end
        end
    end
    descriptor.valid = 1'b1;
    descriptor.count = COUNT_W'(count);
    tick();
    descriptor.valid = 1'b0;
    tick();
    check_value("config_req", 32'(config_req), 32'd1);
endtask

task automatic wait_for_counts(input int rx_target, input int done_target);
    int waited;
    waited = 0;
    while (received < rx_target || done_count < done_target) begin
        tick();
        waited++;
        assert (waited < 1000)
            else fail_test($sformatf("Run stalled with %0d of %0d packets and %0d of %0d done",
                                     received, rx_target, done_count, done_target));
    end
endtask

// Nothing left over once a run has drained
task automatic check_run_end(input int done_target);
    repeat (3) tick();
    check_value("done pulses", 32'(done_count), 32'(done_target));
    check_value("out_empty", 32'(out_empty), 32'd1);
    check_value("config_req", 32'(config_req), 32'd0);
    check_value("unread merged packets", 32'(mask_q.size()), 32'd0);
    for (int i = 0; i < NUM_LANES; i++) begin
        check_value($sformatf("unmerged lane %0d packets", i), 32'(ref_q[i].size()), 32'd0);
    end
endtask

task automatic reset_state_test();
    check_value("config_req", 32'(config_req), 32'd0);
    check_value("done", 32'(done), 32'd0);
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("out_empty", 32'(out_empty), 32'd1);
    check_value("lane_prog_full", 32'(lane_prog_full), 32'd0);
endtask

task automatic full_mask_test();
    int base_rx;
    int base_done;
    int base_cfg;
    base_rx     = received;
    base_done   = done_count;
    base_cfg    = config_count;
    consumer_on = 1'b1;
    begin_run(4'b1111, 4'b1111, 6);
    wait_for_counts(base_rx + 6, base_done + 1);
    check_run_end(base_done + 1);
    check_value("config handshakes", 32'(config_count - base_cfg), 32'd1);
endtask

// Lanes 1 and 3 carry packets that are only drained
task automatic partial_mask_test();
    int base_rx;
    int base_done;
    base_rx   = received;
    base_done = done_count;
    begin_run(4'b0101, 4'b1111, 5);
    wait_for_counts(base_rx + 5, base_done + 1);
    check_run_end(base_done + 1);
endtask

task automatic back_pressure_test();
    int base_rx;
    int base_done;
    int waited;
    int steady;
    base_rx     = received;
    base_done   = done_count;
    waited      = 0;
    steady      = 0;
    consumer_on = 1'b0;
    begin_run(4'b1111, 4'b1111, 20);
    // Lanes only stay full once the output FIFO has halted the merge
    while (steady < 16) begin
        tick();
        waited++;
        if (lane_prog_full == '1) begin
            steady++;
        end else begin
            steady = 0;
        end
        assert (waited < 500)
            else fail_test("lane_prog_full never stayed high while the consumer was stalled");
    end
    check_value("packets read during stall", 32'(received - base_rx), 32'd0);
    check_value("out_empty", 32'(out_empty), 32'd0);
    consumer_on = 1'b1;
    wait_for_counts(base_rx + 20, base_done + 1);
    check_run_end(base_done + 1);
endtask

// Each lane starts late and pushes with its own spacing
task automatic skewed_arrival_test();
    int base_rx;
    int base_done;
    base_rx   = received;
    base_done = done_count;
    for (int i = 0; i < NUM_LANES; i++) begin
        hold[i] = int'(take_bits(4));
        gap[i]  = int'(take_bits(2));
    end
    begin_run(4'b1111, 4'b1111, 8);
    wait_for_counts(base_rx + 8, base_done + 1);
    check_run_end(base_done + 1);
    for (int i = 0; i < NUM_LANES; i++) begin
        gap[i] = 0;
    end
endtask

task automatic back_to_back_test();
    int base_rx;
    int base_done;
    base_rx   = received;
    base_done = done_count;
    begin_run(4'b1011, 4'b1111, 4);
    wait_for_counts(0, base_done + 1);
    // Lanes 2 and 3 stay idle, the old mask would stall here
    begin_run(4'b0011, 4'b0011, 3);
    wait_for_counts(base_rx + 7, base_done + 2);
    check_run_end(base_done + 2);
endtask

`endif

// ==== dv/tb_merge_data_generator.sv ====
// Testbench top with clock, reset, DUT, LFSR, lane driver, config responder and output checker
module tb_merge_data_generator;
    import merge_pkg::*;

    // Pushes over all tests, 24 + 20 + 80 + 32 + 22
    localparam int TOTAL_PUSHES   = 178;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_PUSHES + 2000;

    logic                 ap_clk;
    logic                 areset_generator;
    descriptor_t          descriptor;
    logic                 config_req;
    logic                 config_ack;
    lane_mask_t           config_mask;
    logic [NUM_LANES-1:0] lane_push;
    packet_t              lane_packet [NUM_LANES];
    logic [NUM_LANES-1:0] lane_prog_full;
    logic                 out_rd_en;
    logic                 out_empty;
    logic                 out_valid;
    packet_t              out_packet;
    logic                 done;

    // Stimulus queues and reference model
    logic [31:0] lfsr = 32'hc444_6909;
    packet_t     send_q [NUM_LANES][$];
    packet_t     ref_q [NUM_LANES][$];
    lane_mask_t  mask_q [$];
    lane_mask_t  cur_mask;
    int          hold [NUM_LANES];
    int          gap [NUM_LANES];
    logic        consumer_on;
    logic        prev_done;
    int          received = 0;
    int          done_count = 0;
    int          config_count = 0;
    int          cycle_count = 0;

    merge_data_generator DUT (.*);

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic tick();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic fail_test(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Stopped at the first failed check");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
            else fail_test($sformatf("Error at %0t: %s is 0x%0h, expected 0x%0h",
                                     $time, name, got, exp));
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic packet_t random_packet();
        packet_t p;
        p.meta = META_W'(take_bits(META_W));
        for (int j = 0; j < NUM_LANES; j++) begin
            p.field[j] = take_bits(FIELD_W);
        end
        return p;
    endfunction

    // Meta from lane 0, field j from lane j, masked lanes only
    task automatic check_output();
        lane_mask_t mask;
        packet_t    expected;
        if (mask_q.size() == 0) begin
            fail_test("Merged packet appeared with no run expecting one");
        end else begin
            mask = mask_q.pop_front();
            for (int j = 0; j < NUM_LANES; j++) begin
                if (mask[j] && ref_q[j].size() == 0) begin
                    fail_test($sformatf("Merged packet appeared before lane %0d sent one", j));
                end else if (mask[j]) begin
                    expected = ref_q[j].pop_front();
                    if (j == 0) begin
                        check_value("out_packet.meta", 32'(out_packet.meta),
                                    32'(expected.meta));
                    end
                    check_value($sformatf("out_packet.field[%0d]", j),
                                out_packet.field[j], expected.field[j]);
                end
            end
            received++;
        end
    endtask

    // Four-phase config source
    task automatic answer_config();
        do tick(); while (config_req !== 1'b1);
        config_ack  = 1'b1;
        config_mask = cur_mask;
        tick();
        while (config_req) tick();
        config_ack  = 1'b0;
        config_mask = '0;
        config_count++;
    endtask

    `include "merge_tests.svh"

    // --------------------
    // Background processes
    // --------------------
    initial begin
        forever answer_config();
    end

    // Lane sources, held off by hold counters and lane_prog_full
    always begin
        tick();
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_push[i] = 1'b0;
            if (send_q[i].size() != 0 && !lane_prog_full[i]) begin
                if (hold[i] > 0) begin
                    hold[i]--;
                end else begin
                    lane_packet[i] = send_q[i].pop_front();
                    lane_push[i]   = 1'b1;
                    hold[i]        = gap[i];
                    if (cur_mask[i]) begin
                        ref_q[i].push_back(lane_packet[i]);
                    end
                end
            end
        end
    end

    // Consumer and done monitor
    always begin
        tick();
        if (done) begin
            assert (!prev_done) else fail_test("done stayed high for more than one cycle");
            done_count++;
        end
        prev_done = done;
        // A read shows up on the output one cycle later
        check_value("out_valid", 32'(out_valid), 32'(out_rd_en));
        if (out_valid) begin
            check_output();
        end
        out_rd_en = consumer_on & ~out_empty;
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_test($sformatf("Timeout: tests did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        areset_generator = 1'b1;
        descriptor       = '0;
        config_ack       = 1'b0;
        config_mask      = '0;
        lane_push        = '0;
        out_rd_en        = 1'b0;
        cur_mask         = '0;
        consumer_on      = 1'b0;
        prev_done        = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_packet[i] = '0;
            hold[i]        = 0;
            gap[i]         = 0;
        end
        repeat (3) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;
        reset_state_test();
        full_mask_test();
        partial_mask_test();
        back_pressure_test();
        skewed_arrival_test();
        back_to_back_test();
        repeat (4) tick();
        $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_merge_data_generator

// ==== project.f ====
+incdir+dv
common/merge_pkg.sv
design/sync_fifo.sv
design/merge/merge_control_fsm.sv
design/merge/merge_field_combiner.sv
design/merge_data_generator.sv
dv/tb_merge_data_generator.sv
